// File: board_specific_top.f
design/board_pkg.sv
design/inmp441_mic_i2s_receiver.sv
design/tm1638_board_controller.sv
design/lab_top.sv
design/board_specific_top.sv
dv/tb_board_models.sv
dv/tb_board_specific_top.sv

// File: dv/tb_board_specific_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_board_specific_top;

    localparam int w = board_pkg::w_mic;

    // Samples per test 0, 7, 3, 5, 7 and refreshes per test 1, 4, 2, 7, 12
    localparam int total_samples   = 22;
    localparam int total_refreshes = 26;
    localparam int cycle_limit     = 2 * (total_samples * 512 + total_refreshes * 1700);

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic [2:0]           sw;
    wire                  mic_sd;
    wire                  mic_sck;
    wire                  mic_ws;
    wire                  mic_lr;
    wire                  tm_clk;
    wire                  tm_stb;
    wire                  tm_dio;

    int                   words_sent;
    int                   refresh_count;
    int                   tm_errors;
    board_pkg::tm_frame_t frame_seen;
    board_pkg::tm_keys_t  key_vector;

    // Reference state
    logic [w - 1:0]       accepted [$];  // Samples taken since the last clear
    logic [w - 1:0]       ref_last;
    logic                 ref_overrun;
    int                   pushed;

    int                   errors;
    int                   cycles;
    int                   tests_run;
    int                   tests_failed;
    int                   test_start_errors;
    int unsigned          seed_value;

    event                 compare_now;
    board_pkg::tm_frame_t want_frame;
    board_pkg::tm_keys_t  want_keys;
    logic                 with_keys;

    always #4 clk = ~clk;

    board_specific_top i_dut
    (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .sw      ( sw      ),
        .mic_sd  ( mic_sd  ),
        .mic_sck ( mic_sck ),
        .mic_ws  ( mic_ws  ),
        .mic_lr  ( mic_lr  ),
        .tm_clk  ( tm_clk  ),
        .tm_stb  ( tm_stb  ),
        .tm_dio  ( tm_dio  )
    );

    tb_mic_model i_mic
    (
        .rst_n      ( rst_n      ),
        .sck        ( mic_sck    ),
        .ws         ( mic_ws     ),
        .sd         ( mic_sd     ),
        .words_sent ( words_sent )
    );

    tb_tm1638_model i_tm
    (
        .sio_clk       ( tm_clk        ),
        .sio_stb       ( tm_stb        ),
        .sio_dio       ( tm_dio        ),
        .keys_pressed  ( key_vector    ),
        .frame_seen    ( frame_seen    ),
        .refresh_count ( refresh_count ),
        .error_count   ( tm_errors     )
    );

    // ------------------------------------------------
    // Reference model

    function automatic logic [7:0] segment_pattern (input logic [3:0] nibble);
        logic [7:0] table_hgfedcba [0:15];
        table_hgfedcba = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
                           8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
        return table_hgfedcba[nibble];
    endfunction

    function automatic logic [w - 1:0] magnitude_of (input logic [w - 1:0] value);
        int s;
        s = $signed(value);  // Sign extends to 32 bits
        if (s < 0)
            s = -s;
        return s[w - 1:0];
    endfunction

    function automatic board_pkg::tm_frame_t expected_frame (input logic [2:0] sw_val,
                                                             input logic       overrun);
        board_pkg::tm_frame_t f;
        logic [w - 1:0]       peak;
        logic [w - 1:0]       shown;
        int                   level;
        peak = '0;
        foreach (accepted[i])
            if (magnitude_of(accepted[i]) > peak)
                peak = magnitude_of(accepted[i]);
        shown = sw_val[0] ? ref_last : peak;
        level = 0;
        for (int b = 0; b < w; b++)
            if (peak[b])
                level = b / 3;  // Highest set bit wins
        if (level > 7)
            level = 7;
        f.digits[0] = 8'h00;
        f.digits[1] = 8'h00;
        for (int d = 0; d < 6; d++)
            f.digits[2 + d] = segment_pattern(shown[w - 1 - 4 * d -: 4]);
        for (int j = 0; j < 7; j++)
            f.leds[j] = j < level;
        f.leds[7] = overrun;
        return f;
    endfunction

    // ------------------------------------------------
    // Compare process

    task automatic check_frame (input board_pkg::tm_frame_t got,
                                input board_pkg::tm_frame_t exp, input string name);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_keys (input board_pkg::tm_keys_t got,
                               input board_pkg::tm_keys_t exp, input string name);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit (input logic got, input logic exp, input string name);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    always @(compare_now)
    begin
        check_frame(frame_seen, want_frame, "frame");
        check_bit(mic_lr, 1'b0, "mic_lr");  // Left channel select
        if (with_keys)
            check_keys(i_dut.keys, want_keys, "keys");
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("Timeout after %0d cycles, the tests did not complete", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------------------------
    // Stimulus helpers

    task automatic request_check (input logic keys_too);
        want_frame = expected_frame(sw, ref_overrun);
        want_keys  = key_vector;
        with_keys  = keys_too;
        -> compare_now;
        @(negedge clk);
    endtask

    task automatic push_sample (input logic [w - 1:0] value, input logic taken);
        i_mic.push_sample(value);
        pushed++;
        if (taken)
        begin
            accepted.push_back(value);
            ref_last = value;
        end
    endtask

    task automatic wait_sent;
        while (words_sent < pushed)
            @(posedge clk);
    endtask

    task automatic wait_refreshes (input int n);
        int target;
        target = refresh_count + n;
        while (refresh_count < target)
            @(posedge clk);
    endtask

    task automatic set_keys (input board_pkg::tm_keys_t value);
        @(negedge clk);
        key_vector = value;
    endtask

    task automatic finish_test (input string name);
        int now_errors;
        now_errors = errors + tm_errors;
        tests_run++;
        if (now_errors != test_start_errors)
            tests_failed++;
        $display("Test %0d %s: %s", tests_run, name,
                 now_errors == test_start_errors ? "ok" : "failed");
        test_start_errors = now_errors;
    endtask

    // ------------------------------------------------
    // Tests

    initial
    begin
        logic [w - 1:0] v;
        seed_value   = $urandom(32'h975b_78d1);
        rst_n        = 1'b0;
        sw           = 3'b000;
        key_vector   = 8'hfc;  // Keys 2 to 7 only, the lab logic ignores them
        ref_last     = '0;
        ref_overrun  = 1'b0;
        pushed       = 0;
        errors       = 0;
        cycles       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_start_errors = 0;
        with_keys    = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        wait_refreshes(1);
        request_check(1'b1);
        finish_test("reset image");

        for (int i = 0; i < 6; i++)
            push_sample(w'($urandom), 1'b1);
        wait_sent;
        wait_refreshes(2);
        request_check(1'b0);
        push_sample(24'h800000, 1'b1);  // Most negative value
        wait_sent;
        wait_refreshes(2);
        request_check(1'b0);
        finish_test("random peak");

        sw = 3'b101;
        for (int i = 0; i < 3; i++)
            push_sample(w'($urandom), 1'b1);
        wait_sent;
        wait_refreshes(2);
        request_check(1'b0);
        finish_test("last sample");

        sw = 3'b000;
        push_sample('0, 1'b1);  // Zero is what the source repeats during the clear
        wait_sent;
        set_keys(8'h01);
        accepted.delete();
        ref_overrun = 1'b0;
        wait_refreshes(3);
        request_check(1'b1);
        set_keys(8'h00);
        wait_refreshes(2);
        @(negedge clk);
        for (int i = 0; i < 4; i++)
        begin
            v = w'($urandom % 65536);
            if ($urandom % 2)
                v = -v;
            push_sample(v, 1'b1);
        end
        wait_sent;
        wait_refreshes(2);
        request_check(1'b1);
        finish_test("peak clear");

        // Two repeats of the last word take the credits, the rest are dropped
        set_keys(8'h02);
        ref_overrun = 1'b1;
        wait_refreshes(3);
        @(negedge clk);
        for (int i = 0; i < 3; i++)
            push_sample(w'($urandom), 1'b0);
        push_sample('0, 1'b0);
        wait_sent;
        wait_refreshes(2);
        request_check(1'b1);
        set_keys(8'h01);
        accepted.delete();
        ref_overrun = 1'b0;
        ref_last    = '0;  // Repeated zero is taken once credits return
        wait_refreshes(3);
        request_check(1'b1);
        set_keys(8'h00);
        sw = 3'b001;
        wait_refreshes(2);
        @(negedge clk);
        for (int i = 0; i < 3; i++)
            push_sample(w'($urandom), 1'b1);
        wait_sent;
        wait_refreshes(2);
        request_check(1'b1);
        finish_test("hold and overrun");

        errors = errors + tm_errors;
        $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_board_models.sv
`timescale 1ns/1ns
`default_nettype none

// ------------------------------------------------
// INMP441 sample source, left slot only

module tb_mic_model
(
    input  wire  rst_n,
    input  wire  sck,
    input  wire  ws,
    output logic sd,
    output int   words_sent
);

    localparam int w = board_pkg::w_mic;

    logic [w - 1:0] pending [$];
    logic [w - 1:0] word;
    logic           word_queued;
    logic           ws_prev;
    int             slot;
    int             nxt;

    initial
        sd = 1'b0;  // Quiet line until the first bit clock

    task automatic push_sample (input logic [w - 1:0] value);
        pending.push_back(value);
    endtask

    // Slot 0 is the first rising edge after word select falls
    always @(posedge sck)
    begin
        if (~ws && ws_prev)
            slot = 0;
        else
            slot = (slot + 1) % 64;
        ws_prev = ws;
    end

    always @(negedge sck)
        if (!rst_n)
        begin
            slot        = 63;
            ws_prev     = 1'b0;
            word        = '0;
            word_queued = 1'b0;
            sd          = 1'b0;
            words_sent  = 0;
        end
        else
        begin
            nxt = (slot + 1) % 64;
            if (nxt == 1)
            begin
                word_queued = pending.size() != 0;
                if (word_queued)
                    word = pending.pop_front();  // Empty queue repeats the previous word
            end
            if (nxt == 25 && word_queued)
                words_sent++;
            sd = (nxt >= 1 && nxt <= w) ? word[w - nxt] : 1'b0;  // MSB first
        end

endmodule

// ------------------------------------------------
// TM1638 frame capture and key answer

module tb_tm1638_model
(
    input  wire                  sio_clk,
    input  wire                  sio_stb,
    inout  wire                  sio_dio,
    input  board_pkg::tm_keys_t  keys_pressed,
    output board_pkg::tm_frame_t frame_seen,
    output int                   refresh_count,
    output int                   error_count
);

    logic [7:0]           seg_bytes [0:17];
    logic [7:0]           shift;
    int                   n_bits;
    int                   n_bytes;
    int                   phase;  // 0 write command, 1 display data, 2 key read
    int                   k;
    logic                 seg_active;
    logic                 reading;
    logic                 drive_en;
    logic                 drive_val;
    board_pkg::tm_frame_t frame_acc;

    assign sio_dio = drive_en ? drive_val : 1'bz;

    initial
    begin
        seg_active    = 1'b0;
        reading       = 1'b0;
        drive_en      = 1'b0;
        drive_val     = 1'b0;
        phase         = 0;
        refresh_count = 0;
        error_count   = 0;
        frame_seen    = '0;
    end

    task automatic protocol_error (input string what);
        error_count++;
        $display("TM1638 model at %0t: %s", $time, what);
    endtask

    always @(negedge sio_stb)
    begin
        seg_active = 1'b1;
        reading    = 1'b0;
        n_bits     = 0;
        n_bytes    = 0;
    end

    always @(posedge sio_clk)
        if (seg_active && !sio_stb)
        begin
            if (!reading)
            begin
                shift[n_bits % 8] = sio_dio;  // LSB first
                if (n_bits % 8 == 7)
                begin
                    if (n_bytes < 18)
                        seg_bytes[n_bytes] = shift;
                    n_bytes++;
                    reading = n_bytes == 1 && shift == board_pkg::tm_cmd_read;
                end
            end
            n_bits++;
        end

    // Bit 0 carries key 2k and bit 4 carries key 2k+1
    always @(negedge sio_clk)
        if (seg_active && reading && n_bits >= 8 && n_bits < 40)
        begin
            k        = (n_bits - 8) / 8;
            drive_en = 1'b1;
            case ((n_bits - 8) % 8)
                0:       drive_val = keys_pressed[2 * k];
                4:       drive_val = keys_pressed[2 * k + 1];
                default: drive_val = 1'b0;
            endcase
        end

    always @(posedge sio_stb)
        if (seg_active)
        begin
            seg_active = 1'b0;
            drive_en   = 1'b0;
            case (phase)
                0:
                    if (n_bits == 8 && seg_bytes[0] == board_pkg::tm_cmd_write)
                        phase = 1;
                    else
                        protocol_error("a refresh did not begin with the data write command");
                1:
                begin
                    if (n_bits == 136 && seg_bytes[0] == board_pkg::tm_addr_base)
                    begin
                        for (int i = 0; i < 8; i++)
                        begin
                            frame_acc.digits[i] = seg_bytes[1 + 2 * i];
                            frame_acc.leds[i]   = seg_bytes[2 + 2 * i][0];
                            if (seg_bytes[2 + 2 * i][7:1] != 7'b0)
                                protocol_error("an LED byte has bits set above bit 0");
                        end
                        phase = 2;
                    end
                    else
                    begin
                        protocol_error("the display data has the wrong length or address");
                        phase = 0;
                    end
                end
                default:
                begin
                    if (reading && n_bits == 40)
                    begin
                        frame_seen = frame_acc;
                        refresh_count++;
                    end
                    else
                        protocol_error("the key read is not a read command and four bytes");
                    phase = 0;
                end
            endcase
        end

endmodule

`default_nettype wire

// File: design/board_specific_top.sv
`timescale 1ns/1ns
`default_nettype none

module board_specific_top
#(
    parameter clk_mhz     = 27,
              sck_div     = 4,
              tm_div      = 4,
              mic_credits = 2
)
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic [2:0] sw,

    input  logic       mic_sd,
    output logic       mic_sck,
    output logic       mic_ws,
    output logic       mic_lr,

    output logic       tm_clk,
    output logic       tm_stb,
    inout  wire        tm_dio
);

    board_pkg::mic_sample_t sample;
    logic                   sample_valid;
    logic                   sample_drop;
    logic                   credit_return;
    board_pkg::tm_keys_t    keys;
    board_pkg::tm_frame_t   frame;

    // ------------------------------------------------

    inmp441_mic_i2s_receiver
    #(
        .sck_div     ( sck_div     ),
        .mic_credits ( mic_credits )
    )
    i_microphone
    (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .sck           ( mic_sck       ),
        .ws            ( mic_ws        ),
        .lr            ( mic_lr        ),
        .sd            ( mic_sd        ),
        .sample        ( sample        ),
        .sample_valid  ( sample_valid  ),
        .sample_drop   ( sample_drop   ),
        .credit_return ( credit_return )
    );

    tm1638_board_controller
    #(
        .clk_mhz ( clk_mhz ),
        .tm_div  ( tm_div  )
    )
    i_tm1638
    (
        .clk     ( clk    ),
        .rst_n   ( rst_n  ),
        .frame   ( frame  ),
        .keys    ( keys   ),
        .sio_clk ( tm_clk ),
        .sio_stb ( tm_stb ),
        .sio_dio ( tm_dio )
    );

    lab_top i_lab_top
    (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .sw            ( sw            ),
        .sample        ( sample        ),
        .sample_valid  ( sample_valid  ),
        .sample_drop   ( sample_drop   ),
        .credit_return ( credit_return ),
        .keys          ( keys          ),
        .frame         ( frame         )
    );

endmodule

`default_nettype wire

// File: design/lab_top.sv
`timescale 1ns/1ns
`default_nettype none

module lab_top
(
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic [2:0]             sw,

    input  board_pkg::mic_sample_t sample,
    input  logic                   sample_valid,
    input  logic                   sample_drop,
    output logic                   credit_return,

    input  board_pkg::tm_keys_t    keys,
    output board_pkg::tm_frame_t   frame
);

    localparam w = board_pkg::w_mic;

    logic                   clear;
    logic                   hold;
    logic [w - 1:0]         magnitude;
    logic [w - 1:0]         peak;
    logic signed [w - 1:0]  last;
    logic                   overrun;
    board_pkg::credit_cnt_t owed;
    logic [w - 1:0]         shown;
    logic [4:0]             msb_pos;
    logic [2:0]             level;

    assign clear = keys [0];
    assign hold  = keys [1];

    // Most negative value gives 24'h800000 which still fits unsigned
    assign magnitude = sample.value [w - 1] ? ~ sample.value + 1'b1 : sample.value;

    // ------------------------------------------------
    // Sample consumer

    always_ff @ (posedge clk)
        if (~ rst_n)
        begin
            peak    <= '0;
            last    <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            if (sample_valid)
                last <= sample.value;

            if (clear)
            begin
                peak    <= '0;
                overrun <= 1'b0;
            end
            else
            begin
                if (sample_valid && magnitude > peak)
                    peak <= magnitude;
                if (sample_drop)
                    overrun <= 1'b1;  // Sticky until key 0
            end
        end

    // Credits held back during hold are paid out one per cycle after release
    always_ff @ (posedge clk)
        if (~ rst_n)
        begin
            credit_return <= 1'b0;
            owed          <= '0;
        end
        else
        begin
            credit_return <= 1'b0;

            if (sample_valid && ~ hold)
                credit_return <= 1'b1;
            else if (sample_valid)
                owed <= owed + 1'b1;
            else if (~ hold && owed != '0)
            begin
                credit_return <= 1'b1;
                owed          <= owed - 1'b1;
            end
        end

    // ------------------------------------------------
    // Level bar and display image

    always_comb
    begin
        msb_pos = '0;

        for (int i = 0; i < w; i ++)
            if (peak [i])
                msb_pos = 5'(i);

        level = peak == '0 ? 3'd0 : 3'(msb_pos / 5'd3);
    end

    always_comb
    begin
        shown = sw [0] ? last : peak;

        frame.digits [0] = 8'h00;
        frame.digits [1] = 8'h00;  // Both left digits blank

        for (int i = 0; i < 6; i ++)
            frame.digits [2 + i] = board_pkg::hex_to_segments (shown [w - 1 - 4 * i -: 4]);

        for (int j = 0; j < 7; j ++)
            frame.leds [j] = j < level;

        frame.leds [7] = overrun;
    end

endmodule

`default_nettype wire

// File: design/tm1638_board_controller.sv
`timescale 1ns/1ns
`default_nettype none

module tm1638_board_controller
#(
    parameter clk_mhz = 27,
              tm_div  = 4
)
(
    input  logic                 clk,
    input  logic                 rst_n,

    input  board_pkg::tm_frame_t frame,
    output board_pkg::tm_keys_t  keys,

    output logic                 sio_clk,
    output logic                 sio_stb,
    inout  wire                  sio_dio
);

    // Byte positions within one refresh
    localparam last_cmd   = 0;   // Write command
    localparam last_data  = 17;  // Address then 16 display bytes
    localparam first_read = 19;  // Read command is one byte before
    localparam last_read  = 22;

    localparam w_cnt = $clog2 (clk_mhz > tm_div ? clk_mhz : tm_div) + 1;

    localparam [w_cnt - 1:0] gap_last  = w_cnt'(clk_mhz - 1);  // About 1 us strobe high
    localparam [w_cnt - 1:0] half_last = w_cnt'(tm_div  - 1);

    typedef enum logic [1:0]
    {
        s_gap,
        s_start,
        s_low,
        s_high
    }
    state_t;

    state_t               state;
    logic [w_cnt - 1:0]   cnt;
    logic [4:0]           byte_idx;
    logic [2:0]           bit_idx;
    logic [3:0]           data_idx;
    logic [1:0]           key_slot;
    logic [7:0]           tx_byte;
    logic                 seg_end;
    logic                 reading;
    logic                 dio_oe;
    board_pkg::tm_keys_t  key_acc;
    board_pkg::tm_frame_t frame_q;

    // ------------------------------------------------
    // Byte selection

    assign data_idx = 4'(byte_idx - 5'd2);
    assign key_slot = 2'(byte_idx - 5'(first_read));
    assign reading  = byte_idx >= 5'(first_read);
    assign seg_end  = byte_idx == 5'(last_cmd)
                   || byte_idx == 5'(last_data)
                   || byte_idx == 5'(last_read);

    always_comb
    begin
        tx_byte = 8'h00;

        if (byte_idx == 5'(last_cmd))
            tx_byte = board_pkg::tm_cmd_write;
        else if (byte_idx == 5'(last_cmd + 1))
            tx_byte = board_pkg::tm_addr_base;
        else if (byte_idx <= 5'(last_data))
            tx_byte = data_idx [0] ? { 7'b0, frame_q.leds [data_idx [3:1]] }
                                   : frame_q.digits [data_idx [3:1]];
        else if (byte_idx == 5'(first_read - 1))
            tx_byte = board_pkg::tm_cmd_read;
    end

    // Data changes with the clock fall and is released for key bytes
    assign dio_oe  = state != s_gap && ~ reading;
    assign sio_dio = dio_oe ? tx_byte [bit_idx] : 1'bz;

    // ------------------------------------------------
    // Refresh sequencer

    always_ff @ (posedge clk)
        if (~ rst_n)
        begin
            state    <= s_gap;
            cnt      <= '0;
            byte_idx <= '0;
            bit_idx  <= '0;
            sio_clk  <= 1'b1;
            sio_stb  <= 1'b1;
            key_acc  <= '0;
            keys     <= '0;
        end
        else
        begin
            cnt <= cnt + 1'b1;

            case (state)
                s_gap:
                    if (cnt == gap_last)
                    begin
                        cnt     <= '0;
                        state   <= s_start;
                        sio_stb <= 1'b0;
                    end

                s_start:  // Strobe low ahead of the first clock fall
                    if (cnt == half_last)
                    begin
                        cnt     <= '0;
                        state   <= s_low;
                        sio_clk <= 1'b0;
                    end

                s_low:
                    if (cnt == half_last)
                    begin
                        cnt     <= '0;
                        state   <= s_high;
                        sio_clk <= 1'b1;

                        // Key n in bit 0, key n+1 in bit 4
                        if (reading && bit_idx == 3'd0)
                            key_acc [{ key_slot, 1'b0 }] <= sio_dio;
                        if (reading && bit_idx == 3'd4)
                            key_acc [{ key_slot, 1'b1 }] <= sio_dio;
                    end

                s_high:
                    if (cnt == half_last)
                    begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;

                        if (bit_idx != 3'd7)
                        begin
                            state   <= s_low;
                            sio_clk <= 1'b0;
                        end
                        else if (seg_end)
                        begin
                            state   <= s_gap;
                            sio_stb <= 1'b1;

                            if (byte_idx == 5'(last_read))
                            begin
                                byte_idx <= '0;
                                keys     <= key_acc;
                            end
                            else
                            begin
                                byte_idx <= byte_idx + 1'b1;
                            end
                        end
                        else
                        begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= s_low;
                            sio_clk  <= 1'b0;
                        end
                    end

                default:
                    state <= s_gap;
            endcase
        end

    // One image per refresh
    always_ff @ (posedge clk)
        if (state == s_gap && cnt == gap_last && byte_idx == '0)
            frame_q <= frame;

endmodule

`default_nettype wire

// File: design/inmp441_mic_i2s_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module inmp441_mic_i2s_receiver
#(
    parameter sck_div     = 4,
              mic_credits = 2
)
(
    input  logic                   clk,
    input  logic                   rst_n,

    output logic                   sck,
    output logic                   ws,
    output logic                   lr,
    input  logic                   sd,

    output board_pkg::mic_sample_t sample,
    output logic                   sample_valid,
    output logic                   sample_drop,
    input  logic                   credit_return
);

    localparam w_div = sck_div > 1 ? $clog2 (sck_div) : 1;
    localparam w_mic = board_pkg::w_mic;

    logic [w_div - 1:0]     div_cnt;
    logic                   sck_edge;
    logic                   sck_rise;
    logic                   sck_fall;
    logic [5:0]             slot;
    logic [5:0]             next_slot;
    logic [w_mic - 1:0]     shift;
    logic                   word_done;
    logic                   send;
    board_pkg::credit_cnt_t credits;

    assign lr = 1'b0;  // Left channel

    // ------------------------------------------------
    // Bit clock and word select

    assign sck_edge  = (div_cnt == w_div'(sck_div - 1));
    assign sck_rise  = sck_edge & ~ sck;
    assign sck_fall  = sck_edge &   sck;
    assign next_slot = slot + 6'd1;

    always_ff @ (posedge clk)
        if (~ rst_n)
            div_cnt <= '0;
        else if (sck_edge)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;

    always_ff @ (posedge clk)
        if (~ rst_n)
        begin
            sck  <= 1'b0;
            ws   <= 1'b0;
            slot <= '0;
        end
        else
        begin
            if (sck_edge)
                sck <= ~ sck;

            if (sck_fall)
            begin
                slot <= next_slot;
                ws   <= next_slot [5];  // Low for slots 0 to 31
            end
        end

    // ------------------------------------------------
    // Data capture

    // MSB arrives in slot 1 after the word select fall
    always_ff @ (posedge clk)
        if (sck_rise && slot >= 6'd1 && slot <= 6'd24)
            shift <= { shift [w_mic - 2:0], sd };

    always_ff @ (posedge clk)
        if (~ rst_n)
            word_done <= 1'b0;
        else
            word_done <= sck_rise && slot == 6'd24;

    // ------------------------------------------------
    // Credit flow control

    assign send = word_done && credits != '0;

    always_ff @ (posedge clk)
        if (~ rst_n)
        begin
            credits      <= board_pkg::credit_cnt_t'(mic_credits);
            sample_valid <= 1'b0;
            sample_drop  <= 1'b0;
        end
        else
        begin
            sample_valid <= send;
            sample_drop  <= word_done & ~ send;  // No credit left

            case ({ send, credit_return })
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end

    always_ff @ (posedge clk)
        if (send)
            sample.value <= shift;

endmodule

`default_nettype wire

// File: design/board_pkg.sv
`default_nettype none

package board_pkg;

    // ------------------------------------------------
    // Microphone samples and credits

    localparam int w_mic    = 24;
    localparam int w_credit = 4;  // Enough for up to 15 credits in flight

    typedef struct packed {
        logic signed [w_mic - 1:0] value;
    } mic_sample_t;

    typedef logic [w_credit - 1:0] credit_cnt_t;

    // ------------------------------------------------
    // TM1638 keys, display image and commands

    typedef logic [7:0] tm_keys_t;  // 1 = pressed

    typedef struct packed {
        logic [7:0][7:0] digits;  // Segments hgfedcba, index 0 is leftmost
        logic [7:0]      leds;
    } tm_frame_t;

    localparam logic [7:0] tm_cmd_write = 8'h40;  // Data write with auto increment
    localparam logic [7:0] tm_cmd_read  = 8'h42;  // Key scan read
    localparam logic [7:0] tm_addr_base = 8'hc0;  // Display address 0

    function automatic logic [7:0] hex_to_segments (input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'h3f;
            4'h1: return 8'h06;
            4'h2: return 8'h5b;
            4'h3: return 8'h4f;
            4'h4: return 8'h66;
            4'h5: return 8'h6d;
            4'h6: return 8'h7d;
            4'h7: return 8'h07;
            4'h8: return 8'h7f;
            4'h9: return 8'h6f;
            4'ha: return 8'h77;
            4'hb: return 8'h7c;  // Lower case b
            4'hc: return 8'h39;
            4'hd: return 8'h5e;  // Lower case d
            4'he: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

endpackage

`default_nettype wire
